/* all.f */
source/hb_bus_pkg.sv
source/hb_periph_pkg.sv
source/hb_domain.sv
source/hb_debug_regs.sv
source/hb_eint_ctrl.sv
source/hb_system_timer.sv
source/hb_uart_tx.sv
source/hb_top.sv
bench/hb_tb.sv

/* bench/hb_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_tb
  import hb_bus_pkg::*;
  import hb_periph_pkg::*;
;

  localparam int uart_div = 16;

  typedef enum {
    op_write, op_read, op_bit, op_inc, op_same, op_eint, op_irq, op_wait, op_frame
  } tb_op_e;

  logic        hb_clk;
  logic        rst_n;
  logic        ren;
  logic        wen;
  logic [7:0]  raddr;
  logic [7:0]  waddr;
  logic [31:0] wdata;
  logic [7:0]  eint;
  logic        read_finish;
  logic [31:0] rdata;
  logic        irq;
  logic        uart_txd;

  // Stimulus table, one column per queue
  tb_op_e      op_q [$];
  logic [7:0]  addr_q [$];
  logic [31:0] data_q [$];
  logic [31:0] exp_q [$];
  string       name_q [$];

  logic [31:0] rng_state;
  int          errors;
  bit          table_ready;

  hb_top #(
    .TIMER_W        (64),
    .UART_DIV_RESET (uart_div)
  ) dut_i (
    .hb_clk      (hb_clk),
    .rst_n       (rst_n),
    .ren         (ren),
    .wen         (wen),
    .raddr       (raddr),
    .waddr       (waddr),
    .wdata       (wdata),
    .eint        (eint),
    .read_finish (read_finish),
    .rdata       (rdata),
    .irq         (irq),
    .uart_txd    (uart_txd)
  );

  initial begin
    hb_clk = 1'b0;
    forever #5 hb_clk = ~hb_clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_step(input tb_op_e op, input logic [7:0] addr, input logic [31:0] data,
                          input logic [31:0] exp, input string name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
    name_q.push_back(name);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("error %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge hb_clk);
    wen = 1'b1;
    waddr = addr;
    wdata = data;
    @(negedge hb_clk);
    wen = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge hb_clk);
    ren = 1'b1;
    raddr = addr;
    do begin
      @(negedge hb_clk);
      waited++;
    end while (!read_finish && waited < 16);
    assert (read_finish && waited == 1) else begin
      $display("read of address %0d: read_finish not seen one cycle after ren", addr);
      errors++;
    end
    data = rdata;
    ren = 1'b0;
    @(negedge hb_clk);
    assert (!read_finish) else begin
      $display("read of address %0d: read_finish stayed high past one cycle", addr);
      errors++;
    end
  endtask

  task automatic pulse_eint(input logic [2:0] line);
    @(negedge hb_clk);
    eint = 8'(1) << line;
    @(negedge hb_clk);
    eint = '0;
  endtask

  // Samples each bit of one frame in the middle of its bit time
  task automatic sample_frame(output logic [9:0] frame);
    int waited;
    waited = 0;
    frame = '1;
    do begin
      @(negedge hb_clk);
      waited++;
    end while (uart_txd && waited < 64);
    assert (!uart_txd) else begin
      $display("uart_txd never showed a start bit");
      errors++;
    end
    repeat (uart_div / 2) @(negedge hb_clk);
    for (int b = 0; b < 10; b++) begin
      frame[b] = uart_txd;
      if (b < 9) begin
        repeat (uart_div) @(negedge hb_clk);
      end
    end
  endtask

  task automatic apply_step(input int i);
    logic [31:0] got;
    logic [31:0] first;
    logic [9:0]  frame;
    case (op_q[i])
      op_write: bus_write(addr_q[i], data_q[i]);
      op_read: begin
        bus_read(addr_q[i], got);
        check_value(name_q[i], exp_q[i], got);
      end
      op_bit: begin
        bus_read(addr_q[i], got);
        check_value(name_q[i], exp_q[i], 32'(got[data_q[i][4:0]]));
      end
      op_inc, op_same: begin
        bus_read(addr_q[i], first);
        bus_read(addr_q[i], got);
        if (op_q[i] == op_inc) begin
          assert (got > first) else begin
            $display("error %s: expected above %h, got %h", name_q[i], first, got);
            errors++;
          end
        end else begin
          check_value(name_q[i], first, got);
        end
      end
      op_eint: pulse_eint(data_q[i][2:0]);
      op_irq: begin
        @(negedge hb_clk);
        check_value(name_q[i], exp_q[i], 32'(irq));
      end
      op_wait: repeat (data_q[i]) @(negedge hb_clk);
      op_frame: begin
        fork
          sample_frame(frame);
          begin
            bus_write(addr_q[i], data_q[i]);
            bus_read(addr_uart_stat, got);
            check_value({name_q[i], "_busy"}, 32'(1) << uart_busy_bit, got);
            // Second byte lands mid-frame and must be dropped
            bus_write(addr_q[i], data_q[i] ^ 32'hff);
          end
        join
        // 8N1 order with start low first and stop high last
        check_value(name_q[i], 32'({1'b1, exp_q[i][7:0], 1'b0}), 32'(frame));
      end
      default: ;
    endcase
  endtask

  task automatic build_table();
    logic [31:0] scratch_val [4];
    for (int i = 0; i < 4; i++) begin
      rng_state = next_random(rng_state);
      scratch_val[i] = rng_state;
      add_step(op_write, 8'(i), scratch_val[i], 0, $sformatf("scratch_wr%0d", i));
    end
    for (int i = 0; i < 4; i++) begin
      add_step(op_read, 8'(i), 0, scratch_val[i], $sformatf("scratch_rd%0d", i));
    end
    add_step(op_read, 8'd5, 0, 0, "unmapped_rd5");
    add_step(op_read, 8'd9, 0, 0, "unmapped_rd9");
    add_step(op_read, 8'd40, 0, 0, "unmapped_rd40");
    rng_state = next_random(rng_state);
    add_step(op_write, 8'd5, rng_state, 0, "unmapped_wr5");
    add_step(op_write, 8'd9, 32'hff, 0, "unmapped_wr9");
    rng_state = next_random(rng_state);
    add_step(op_write, 8'd40, rng_state, 0, "unmapped_wr40");
    add_step(op_read, 8'd1, 0, scratch_val[1], "scratch1_kept");
    add_step(op_read, addr_eint_en, 0, 0, "eint_en_kept");
    add_step(op_read, 8'd0, 0, scratch_val[0], "scratch0_kept");
    // Interrupt line 3, masked then enabled
    add_step(op_eint, 0, 3, 0, "eint3_pulse");
    add_step(op_irq, 0, 0, 0, "irq_masked");
    add_step(op_write, addr_eint_en, 32'h08, 0, "eint_enable3");
    add_step(op_irq, 0, 0, 1, "irq_raised");
    add_step(op_read, addr_eint_en, 0, 32'h08, "eint_en_rd");
    add_step(op_read, addr_eint_pend, 0, 32'h08, "eint_pend_rd");
    add_step(op_read, addr_eint_pend, 0, 0, "eint_pend_clr");
    add_step(op_irq, 0, 0, 0, "irq_dropped");
    add_step(op_write, addr_timer_ctrl, 32'(cmd_run), 0, "timer_run");
    add_step(op_inc, addr_timer_lo, 0, 0, "timer_counts");
    add_step(op_write, addr_timer_ctrl, 32'(cmd_clear), 0, "timer_clear");
    add_step(op_read, addr_timer_lo, 0, 0, "timer_lo_zero");
    add_step(op_read, addr_timer_hi, 0, 0, "timer_hi_zero");
    add_step(op_write, addr_timer_cmp, 32'd50, 0, "timer_cmp50");
    add_step(op_write, addr_timer_ctrl, 32'(cmd_run), 0, "timer_rerun");
    add_step(op_bit, addr_timer_ctrl, timer_match_bit, 0, "timer_no_match");
    add_step(op_wait, 0, 100, 0, "timer_wait");
    add_step(op_bit, addr_timer_ctrl, timer_match_bit, 1, "timer_match");
    add_step(op_write, addr_timer_ctrl, 32'(cmd_stop), 0, "timer_stop");
    add_step(op_same, addr_timer_lo, 0, 0, "timer_frozen");
    add_step(op_write, addr_uart_ctrl, 32'h1, 0, "uart_enable");
    add_step(op_frame, addr_uart_data, 32'ha5, 32'ha5, "uart_frame_a5");
    // Rest of the stop bit
    add_step(op_wait, 0, 12, 0, "uart_drain");
    add_step(op_read, addr_uart_stat, 0, 0, "uart_idle");
  endtask

  initial begin
    table_ready = 1'b0;
    wait (table_ready);
    repeat (op_q.size() * 400 + 10 * uart_div) @(posedge hb_clk);
    $display("watchdog: run did not finish in time");
    $display("test failed");
    $finish;
  end

  initial begin
    int errors_before;
    rst_n = 1'b0;
    ren = 1'b0;
    wen = 1'b0;
    raddr = '0;
    waddr = '0;
    wdata = '0;
    eint = '0;
    errors = 0;
    rng_state = 32'hb135b190;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge hb_clk);
    @(negedge hb_clk);
    rst_n = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      errors_before = errors;
      apply_step(i);
      if (errors == errors_before) begin
        $display("%s: ok", name_q[i]);
      end else begin
        $display("%s: mismatch", name_q[i]);
      end
    end
    $display("%0d steps run, %0d errors", op_q.size(), errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module hb_tb -f all.f -o hb_sim \
  && ./obj_dir/hb_sim | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }
grep -q "test failed" sim.log && exit 1 || exit 0

/* source/hb_bus_pkg.sv */
`default_nettype none

package hb_bus_pkg;

  // Slave index into the per-slave strobe and read word vectors
  typedef enum logic [1:0] {
    slave_debug,
    slave_eint,
    slave_timer,
    slave_uart
  } hb_slave_e;

  // Word addresses on the host bus
  localparam logic [7:0] addr_debug_base = 8'd0;
  localparam logic [7:0] addr_eint_pend  = 8'd4;
  localparam logic [7:0] addr_eint_en    = 8'd8;
  localparam logic [7:0] addr_timer_lo   = 8'd12;
  localparam logic [7:0] addr_timer_hi   = 8'd16;
  localparam logic [7:0] addr_timer_cmp  = 8'd20;
  localparam logic [7:0] addr_timer_ctrl = 8'd24;
  localparam logic [7:0] addr_uart_data  = 8'd28;
  localparam logic [7:0] addr_uart_stat  = 8'd29;
  localparam logic [7:0] addr_uart_div   = 8'd30;
  localparam logic [7:0] addr_uart_ctrl  = 8'd31;

endpackage

`default_nettype wire

/* source/hb_debug_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_debug_regs (
  input  logic        hb_clk,
  input  logic        rst_n,
  input  logic        wen,
  input  logic [1:0]  waddr,
  input  logic [1:0]  raddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  logic [31:0] scratch [4];

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        scratch[i] <= '0;
      end
    end else if (wen) begin
      scratch[waddr] <= wdata;
    end
  end

  assign rdata = scratch[raddr];

endmodule

`default_nettype wire

/* source/hb_domain.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_domain
  import hb_bus_pkg::*;
(
  input  logic        hb_clk,
  input  logic        rst_n,
  input  logic        ren,
  input  logic        wen,
  input  logic [7:0]  raddr,
  input  logic [7:0]  waddr,
  input  logic [31:0] slave_rdata [4],
  output logic        read_finish,
  output logic [31:0] rdata,
  output logic [3:0]  slave_ren,
  output logic [3:0]  slave_wen
);

  logic [3:0] rsel;
  logic [3:0] wsel;

  // One-hot slave select from the address map
  function automatic logic [3:0] decode_slave(input logic [7:0] addr);
    logic [3:0] sel;
    sel = '0;
    if (addr inside {[addr_debug_base : addr_debug_base + 8'd3]}) begin
      sel[slave_debug] = 1'b1;
    end
    if (addr == addr_eint_pend || addr == addr_eint_en) begin
      sel[slave_eint] = 1'b1;
    end
    if (addr inside {addr_timer_lo, addr_timer_hi, addr_timer_cmp, addr_timer_ctrl}) begin
      sel[slave_timer] = 1'b1;
    end
    if (addr inside {[addr_uart_data : addr_uart_ctrl]}) begin
      sel[slave_uart] = 1'b1;
    end
    return sel;
  endfunction

  assign rsel = decode_slave(raddr);
  assign wsel = decode_slave(waddr);

  // One strobe per read and none while read_finish is high
  assign slave_ren = (ren && !read_finish) ? rsel : 4'b0000;
  assign slave_wen = wen ? wsel : 4'b0000;

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      read_finish <= 1'b0;
    end else if (read_finish) begin
      read_finish <= 1'b0;
    end else if (ren) begin
      read_finish <= 1'b1;
    end
  end

  // Unmapped reads fall through to zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < 4; i++) begin
      if (rsel[i]) begin
        rdata = slave_rdata[i];
      end
    end
  end

endmodule

`default_nettype wire

/* source/hb_eint_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_eint_ctrl
  import hb_periph_pkg::*;
(
  input  logic                  hb_clk,
  input  logic                  rst_n,
  input  logic                  ren,
  input  logic                  wen,
  input  logic [7:0]            waddr,
  input  logic [7:0]            raddr,
  input  logic [31:0]           wdata,
  input  logic [eint_lines-1:0] eint,
  output logic [31:0]           rdata,
  output logic                  irq
);

  logic [eint_lines-1:0] eint_q;
  logic [eint_lines-1:0] rise;
  logic [eint_lines-1:0] pending;
  logic [eint_lines-1:0] enable;
  logic                  clr_pend;

  assign rise = eint & ~eint_q;

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      eint_q   <= '0;
      pending  <= '0;
      enable   <= '0;
      clr_pend <= 1'b0;
    end else begin
      eint_q   <= eint;
      // Clear lands after the finish cycle, so the master sees the bits first
      clr_pend <= ren && !raddr[3];
      pending  <= clr_pend ? rise : (pending | rise);
      if (wen && waddr[3]) begin
        enable <= wdata[eint_lines-1:0];
      end
    end
  end

  assign irq = |(pending & enable);

  // Bit 3 selects enable (8) over pending (4)
  assign rdata = raddr[3] ? {{(32 - eint_lines){1'b0}}, enable}
                          : {{(32 - eint_lines){1'b0}}, pending};

endmodule

`default_nettype wire

/* source/hb_periph_pkg.sv */
`default_nettype none

package hb_periph_pkg;

  // Opcodes for the timer control register
  typedef enum logic [1:0] {
    cmd_stop  = 2'd0,
    cmd_run   = 2'd1,
    cmd_clear = 2'd2
  } timer_cmd_e;

  // Transmitter frame position
  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_e;

  localparam int eint_lines = 8;

  // Bit positions in read words
  localparam int uart_busy_bit   = 0;
  localparam int timer_match_bit = 2;

endpackage

`default_nettype wire

/* source/hb_system_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_system_timer
  import hb_bus_pkg::*;
  import hb_periph_pkg::*;
#(
  parameter int TIMER_W = 64
) (
  input  logic        hb_clk,
  input  logic        rst_n,
  input  logic        wen,
  input  logic [7:0]  waddr,
  input  logic [7:0]  raddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  logic [TIMER_W-1:0] count;
  logic [63:0]        count_ext;
  logic [31:0]        compare;
  logic               running;
  logic               match;
  logic [31:0]        ctrl_word;

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      count   <= '0;
      compare <= '0;
      running <= 1'b0;
      match   <= 1'b0;
    end else begin
      if (running) begin
        count <= count + 1'b1;
      end
      if (running && count[31:0] == compare) begin
        match <= 1'b1;
      end
      if (wen && waddr == addr_timer_cmp) begin
        compare <= wdata;
      end
      // Any control write drops the match flag
      if (wen && waddr == addr_timer_ctrl) begin
        match <= 1'b0;
        case (timer_cmd_e'(wdata[1:0]))
          cmd_run:  running <= 1'b1;
          cmd_stop: running <= 1'b0;
          cmd_clear: begin
            running <= 1'b0;
            count   <= '0;
          end
          default: ;
        endcase
      end
    end
  end

  assign count_ext = 64'(count);

  always_comb begin
    ctrl_word                  = '0;
    ctrl_word[0]               = running;
    ctrl_word[timer_match_bit] = match;
  end

  always_comb begin
    case (raddr)
      addr_timer_lo:   rdata = count_ext[31:0];
      addr_timer_hi:   rdata = count_ext[63:32];
      addr_timer_cmp:  rdata = compare;
      addr_timer_ctrl: rdata = ctrl_word;
      default:         rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/hb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_top
  import hb_bus_pkg::*;
#(
  parameter int TIMER_W        = 64,
  parameter int UART_DIV_RESET = 16
) (
  input  logic        hb_clk,
  input  logic        rst_n,
  input  logic        ren,
  input  logic        wen,
  input  logic [7:0]  raddr,
  input  logic [7:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [7:0]  eint,
  output logic        read_finish,
  output logic [31:0] rdata,
  output logic        irq,
  output logic        uart_txd
);

  logic [31:0] slave_rdata [4];
  logic [3:0]  slave_ren;
  logic [3:0]  slave_wen;

  hb_domain domain_i (
    .hb_clk      (hb_clk),
    .rst_n       (rst_n),
    .ren         (ren),
    .wen         (wen),
    .raddr       (raddr),
    .waddr       (waddr),
    .slave_rdata (slave_rdata),
    .read_finish (read_finish),
    .rdata       (rdata),
    .slave_ren   (slave_ren),
    .slave_wen   (slave_wen)
  );

  hb_debug_regs debug_i (
    .hb_clk (hb_clk),
    .rst_n  (rst_n),
    .wen    (slave_wen[slave_debug]),
    .waddr  (waddr[1:0]),
    .raddr  (raddr[1:0]),
    .wdata  (wdata),
    .rdata  (slave_rdata[slave_debug])
  );

  hb_eint_ctrl eint_i (
    .hb_clk (hb_clk),
    .rst_n  (rst_n),
    .ren    (slave_ren[slave_eint]),
    .wen    (slave_wen[slave_eint]),
    .waddr  (waddr),
    .raddr  (raddr),
    .wdata  (wdata),
    .eint   (eint),
    .rdata  (slave_rdata[slave_eint]),
    .irq    (irq)
  );

  hb_system_timer #(
    .TIMER_W (TIMER_W)
  ) timer_i (
    .hb_clk (hb_clk),
    .rst_n  (rst_n),
    .wen    (slave_wen[slave_timer]),
    .waddr  (waddr),
    .raddr  (raddr),
    .wdata  (wdata),
    .rdata  (slave_rdata[slave_timer])
  );

  hb_uart_tx #(
    .UART_DIV_RESET (UART_DIV_RESET)
  ) uart_i (
    .hb_clk   (hb_clk),
    .rst_n    (rst_n),
    .wen      (slave_wen[slave_uart]),
    .waddr    (waddr[1:0]),
    .raddr    (raddr[1:0]),
    .wdata    (wdata),
    .rdata    (slave_rdata[slave_uart]),
    .uart_txd (uart_txd)
  );

endmodule

`default_nettype wire

/* source/hb_uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module hb_uart_tx
  import hb_bus_pkg::*;
  import hb_periph_pkg::*;
#(
  parameter int UART_DIV_RESET = 16
) (
  input  logic        hb_clk,
  input  logic        rst_n,
  input  logic        wen,
  input  logic [1:0]  waddr,
  input  logic [1:0]  raddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        uart_txd
);

  uart_state_e state;
  logic [15:0] divisor;
  logic [15:0] baud_cnt;
  logic [7:0]  tx_byte;
  logic [7:0]  shift;
  logic [2:0]  bit_idx;
  logic        enable;
  logic        busy;

  assign busy = (state != uart_idle);

  always_ff @(posedge hb_clk) begin
    if (!rst_n) begin
      state    <= uart_idle;
      divisor  <= 16'(UART_DIV_RESET);
      baud_cnt <= '0;
      tx_byte  <= '0;
      shift    <= '0;
      bit_idx  <= '0;
      enable   <= 1'b0;
      uart_txd <= 1'b1;
    end else begin
      if (wen && waddr == addr_uart_div[1:0]) begin
        divisor <= wdata[15:0];
      end
      if (wen && waddr == addr_uart_ctrl[1:0]) begin
        enable <= wdata[0];
      end
      case (state)
        uart_idle: begin
          if (wen && enable && waddr == addr_uart_data[1:0]) begin
            tx_byte  <= wdata[7:0];
            shift    <= wdata[7:0];
            baud_cnt <= divisor - 16'd1;
            uart_txd <= 1'b0;
            state    <= uart_start;
          end
        end
        uart_start: begin
          if (baud_cnt == 16'd0) begin
            uart_txd <= shift[0];
            shift    <= shift >> 1;
            bit_idx  <= '0;
            baud_cnt <= divisor - 16'd1;
            state    <= uart_data;
          end else begin
            baud_cnt <= baud_cnt - 16'd1;
          end
        end
        uart_data: begin
          if (baud_cnt == 16'd0) begin
            baud_cnt <= divisor - 16'd1;
            if (bit_idx == 3'd7) begin
              uart_txd <= 1'b1;
              state    <= uart_stop;
            end else begin
              uart_txd <= shift[0];
              shift    <= shift >> 1;
              bit_idx  <= bit_idx + 3'd1;
            end
          end else begin
            baud_cnt <= baud_cnt - 16'd1;
          end
        end
        uart_stop: begin
          // Wait out the stop bit on a line already high
          if (baud_cnt == 16'd0) begin
            state <= uart_idle;
          end else begin
            baud_cnt <= baud_cnt - 16'd1;
          end
        end
        default: state <= uart_idle;
      endcase
    end
  end

  always_comb begin
    rdata = '0;
    case (raddr)
      addr_uart_data[1:0]: rdata[7:0]           = tx_byte;
      addr_uart_stat[1:0]: rdata[uart_busy_bit] = busy;
      addr_uart_div[1:0]:  rdata[15:0]          = divisor;
      addr_uart_ctrl[1:0]: rdata[0]             = enable;
      default: ;
    endcase
  end

endmodule

`default_nettype wire
